// ==== source/hpsdr_pkg.sv ====
// Upstream packer shared definitions
package hpsdr_pkg;

  localparam int FRAME_LEN     = 1032;  // EP6 and EP4
  localparam int DISC_LEN      = 60;
  localparam int SUBFRAME_LEN  = 512;
  localparam int EP6_THRESHOLD = 334;   // Sample words queued before EP6 starts
  localparam int LEN_W         = 11;    // Byte lengths and FIFO fill level

  localparam logic [7:0] SYNC_BYTE = 8'h7f;
  localparam logic [7:0] MAGIC0    = 8'hef;
  localparam logic [7:0] MAGIC1    = 8'hfe;
  localparam logic [7:0] EP6_ID    = 8'h06;
  localparam logic [7:0] EP4_ID    = 8'h04;

  typedef enum logic [3:0] {
    idle, disc_req, disc_body,
    wide_req, wide_hdr, wide_lo, wide_hi,
    ep6_req, ep6_hdr, sync_resp,
    rx2, rx1, rx0, mic1, mic0, pad
  } pkt_state_e;

  // APB register map
  typedef enum logic [5:0] {
    addr_rx_cfg    = 6'h00,  // Receivers minus one [7:3], speed [25:24]
    addr_vna_cfg   = 6'h09,  // VNA mode in bit 23
    addr_mac_hi    = 6'h10,
    addr_mac_lo    = 6'h11,
    addr_static_ip = 6'h12,
    addr_alt_mac   = 6'h13,
    addr_eeprom    = 6'h14,
    addr_resp_hi   = 6'h15,
    addr_resp_lo   = 6'h16,
    addr_resp_sent = 6'h17   // Read only
  } reg_addr_e;

endpackage

// ==== source/sample_fifo.sv ====
// Show-ahead sample FIFO
`timescale 1ns/100ps

module sample_fifo #(
  parameter int WIDTH      = 24,
  parameter int DEPTH_LOG2 = 9
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wr,
  input  logic [WIDTH-1:0]      wdata,
  input  logic                  rd,
  output logic [WIDTH-1:0]      rdata,
  output logic                  valid,
  output logic [DEPTH_LOG2:0]   level
);

  localparam int DEPTH = 1 << DEPTH_LOG2;

  logic [WIDTH-1:0]      mem [DEPTH];
  logic [DEPTH_LOG2-1:0] wr_ptr;
  logic [DEPTH_LOG2-1:0] rd_ptr;
  logic                  full;
  logic                  do_wr;
  logic                  do_rd;

  assign full  = level[DEPTH_LOG2];  // Only set at level == DEPTH
  assign valid = |level;
  assign do_wr = wr & ~full;
  assign do_rd = rd & valid;
  assign rdata = mem[rd_ptr];        // Head word always on the output

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wdata;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

  // Consumer must only pop what is there
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    rd |-> valid);

  // Producer is sized so the FIFO never overflows
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    wr |-> !full);

endmodule

// ==== source/cmd_regs.sv ====
// Frame settings register block
`timescale 1ns/100ps

module cmd_regs import hpsdr_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [5:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic [6:0]  rx_round_cnt,
  output logic        vna,
  output logic [47:0] mac,
  output logic [31:0] static_ip,
  output logic [15:0] alt_mac,
  output logic [7:0]  eeprom_config,
  output logic [39:0] resp,
  input  logic        resp_toggle
);

  reg_addr_e   addr;
  logic        wr_en;
  logic [4:0]  nrx_m1;
  logic [1:0]  speed;
  logic        toggle_q;
  logic [31:0] resp_sent;

  assign addr  = reg_addr_e'(paddr);
  assign wr_en = psel & penable & pwrite;

  // Receivers per round, scaled by sample rate
  assign rx_round_cnt = ({2'b00, nrx_m1} + 7'd1) << speed;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      nrx_m1        <= '0;
      speed         <= '0;
      vna           <= 1'b0;
      mac           <= '0;
      static_ip     <= '0;
      alt_mac       <= '0;
      eeprom_config <= '0;
      resp          <= '0;
    end else if (wr_en) begin
      case (addr)
        addr_rx_cfg: begin
          nrx_m1 <= pwdata[7:3];
          speed  <= pwdata[25:24];
        end
        addr_vna_cfg:   vna           <= pwdata[23];
        addr_mac_hi:    mac[47:32]    <= pwdata[15:0];
        addr_mac_lo:    mac[31:0]     <= pwdata;
        addr_static_ip: static_ip     <= pwdata;
        addr_alt_mac:   alt_mac       <= pwdata[15:0];
        addr_eeprom:    eeprom_config <= pwdata[7:0];
        addr_resp_hi:   resp[39:32]   <= pwdata[7:0];
        addr_resp_lo:   resp[31:0]    <= pwdata;
        default: ;
      endcase
    end
  end

  // Responses handed to the host, one per toggle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      toggle_q  <= 1'b0;
      resp_sent <= '0;
    end else begin
      toggle_q <= resp_toggle;
      if (resp_toggle != toggle_q) begin
        resp_sent <= resp_sent + 32'd1;
      end
    end
  end

  always_comb begin
    prdata = '0;
    if (psel) begin
      case (addr)
        addr_rx_cfg:    prdata = {6'd0, speed, 16'd0, nrx_m1, 3'd0};
        addr_vna_cfg:   prdata = {8'd0, vna, 23'd0};
        addr_mac_hi:    prdata = {16'd0, mac[47:32]};
        addr_mac_lo:    prdata = mac[31:0];
        addr_static_ip: prdata = static_ip;
        addr_alt_mac:   prdata = {16'd0, alt_mac};
        addr_eeprom:    prdata = {24'd0, eeprom_config};
        addr_resp_hi:   prdata = {24'd0, resp[39:32]};
        addr_resp_lo:   prdata = resp[31:0];
        addr_resp_sent: prdata = resp_sent;
        default:        prdata = '0;
      endcase
    end
  end

  // No wait states, so setup is always followed by access
  a_apb_access: assert property (@(posedge clk) disable iff (!rst_n)
    psel && !penable |=> psel && penable);

endmodule

// ==== source/upstream_packer.sv ====
// Upstream UDP payload packer
`timescale 1ns/100ps

module upstream_packer import hpsdr_pkg::*; #(
  parameter logic [7:0] NR           = 8'd1,
  parameter logic [7:0] SERIAL_NO    = 8'd0,
  parameter logic [7:0] HARD_STATUS1 = 8'h40,
  parameter logic [7:0] BOARD_ID     = 8'h06
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             run,
  input  logic             have_ip,
  input  logic             wide_spectrum,
  input  logic             discovery,
  input  logic [47:0]      mac,
  input  logic [31:0]      static_ip,
  input  logic [15:0]      alt_mac,
  input  logic [7:0]       eeprom_config,
  input  logic             vna,
  input  logic [6:0]       rx_round_cnt,
  input  logic [39:0]      resp,
  output logic             resp_toggle,
  input  logic             us_tvalid,
  output logic             us_tready,
  input  logic [23:0]      us_tdata,
  input  logic             us_tuser,
  input  logic             us_tlast,
  input  logic [LEN_W-1:0] us_tlength,
  input  logic             bs_tvalid,
  output logic             bs_tready,
  input  logic [11:0]      bs_tdata,
  output logic             udp_tx_request,
  output logic [LEN_W-1:0] udp_tx_length,
  output logic [7:0]       udp_tx_data,
  input  logic             udp_tx_enable,
  output logic             watchdog_up
);

  localparam int SUB_W = $clog2(SUBFRAME_LEN);

  pkt_state_e       state, state_next;
  pkt_state_e       after_sub;
  logic [LEN_W-1:0] byte_no, byte_no_next;
  logic [LEN_W-1:0] tx_len_next;
  logic [7:0]       data_q, data_next;
  logic [6:0]       round_bytes, round_bytes_next;
  logic             mic_bit, mic_bit_next;
  logic [31:0]      ep6_seq, ep4_seq;
  logic [31:0]      hdr_seq;
  logic             is_ep6;
  logic [6:0]       bs_cnt;  // EP6 frames until next EP4
  logic             disc_pending;
  logic             ep6_go, ep4_go;
  logic             ep6_inc, ep4_inc, wide_start, resp_done, disc_done;
  logic [5:0]       disc_off;
  logic [SUB_W-1:0] sub_pos, sub_left;
  logic             sub_end;

  assign udp_tx_data = data_q;
  assign ep6_go = run & have_ip & us_tvalid & (us_tlength >= LEN_W'(EP6_THRESHOLD));
  assign ep4_go = wide_spectrum & bs_tvalid & (bs_cnt == '0);

  assign is_ep6   = (state == ep6_hdr);
  assign hdr_seq  = is_ep6 ? ep6_seq : ep4_seq;
  assign disc_off = 6'(DISC_LEN - 2) - byte_no[5:0];
  assign sub_pos  = byte_no[SUB_W-1:0];
  assign sub_left = SUB_W'(SUBFRAME_LEN - 1) - sub_pos;
  assign sub_end  = (sub_pos == '0);
  assign after_sub = byte_no[SUB_W] ? sync_resp : idle;  // Second subframe or done

  always_comb begin
    state_next       = state;
    byte_no_next     = byte_no - LEN_W'(1);
    tx_len_next      = udp_tx_length;
    data_next        = data_q;
    round_bytes_next = round_bytes;
    mic_bit_next     = mic_bit;
    udp_tx_request   = 1'b0;
    us_tready        = 1'b0;
    bs_tready        = 1'b0;
    ep6_inc          = 1'b0;
    ep4_inc          = 1'b0;
    wide_start       = 1'b0;
    resp_done        = 1'b0;
    disc_done        = 1'b0;

    case (state)
      idle: begin
        byte_no_next = byte_no;
        if (discovery | disc_pending) begin
          tx_len_next = LEN_W'(DISC_LEN);
          state_next  = disc_req;
        end else if (ep6_go) begin
          tx_len_next = LEN_W'(FRAME_LEN);
          state_next  = ep6_req;
        end else if (ep4_go) begin
          tx_len_next = LEN_W'(FRAME_LEN);
          wide_start  = 1'b1;
          state_next  = wide_req;
        end
      end

      disc_req: begin
        udp_tx_request = 1'b1;
        byte_no_next   = LEN_W'(DISC_LEN - 2);
        data_next      = MAGIC0;
        if (udp_tx_enable) state_next = disc_body;
      end

      disc_body: begin
        case (disc_off)
          6'd0:    data_next = MAGIC1;
          6'd1:    data_next = run ? 8'h03 : 8'h02;
          6'd2:    data_next = mac[47:40];
          6'd3:    data_next = mac[39:32];
          6'd4:    data_next = mac[31:24];
          6'd5:    data_next = mac[23:16];
          6'd6:    data_next = mac[15:8];
          6'd7:    data_next = mac[7:0];
          6'd8:    data_next = SERIAL_NO;
          6'd9:    data_next = {eeprom_config[7:5], 5'd0};
          6'd10:   data_next = 8'h00;
          6'd11:   data_next = static_ip[31:24];
          6'd12:   data_next = static_ip[23:16];
          6'd13:   data_next = static_ip[15:8];
          6'd14:   data_next = static_ip[7:0];
          6'd15:   data_next = alt_mac[15:8];
          6'd16:   data_next = alt_mac[7:0];
          6'd17:   data_next = NR;
          6'd18:   data_next = HARD_STATUS1;
          default: data_next = BOARD_ID;
        endcase
        if (byte_no == '0) begin
          disc_done  = 1'b1;
          state_next = idle;
        end
      end

      wide_req, ep6_req: begin
        udp_tx_request = 1'b1;
        byte_no_next   = LEN_W'(FRAME_LEN - 2);
        data_next      = MAGIC0;
        if (udp_tx_enable) state_next = (state == ep6_req) ? ep6_hdr : wide_hdr;
      end

      // Header position follows from the low bits of byte_no
      wide_hdr, ep6_hdr: begin
        case (byte_no[2:0])
          3'd6: data_next = MAGIC1;
          3'd5: data_next = 8'h01;
          3'd4: data_next = is_ep6 ? EP6_ID : EP4_ID;
          3'd3: data_next = hdr_seq[31:24];
          3'd2: data_next = hdr_seq[23:16];
          3'd1: data_next = hdr_seq[15:8];
          3'd0: begin
            data_next = hdr_seq[7:0];
            if (is_ep6) begin
              ep6_inc    = 1'b1;
              state_next = sync_resp;
            end else begin
              ep4_inc    = 1'b1;
              state_next = wide_lo;
            end
          end
          default: data_next = 8'h00;
        endcase
      end

      wide_lo: begin
        data_next  = {bs_tdata[3:0], 4'h0};
        state_next = wide_hi;
      end

      wide_hi: begin
        data_next  = bs_tdata[11:4];
        bs_tready  = bs_tvalid;
        state_next = (byte_no == '0) ? idle : wide_lo;
      end

      sync_resp: begin
        round_bytes_next = '0;
        case (sub_left)
          0, 1, 2: data_next = SYNC_BYTE;
          3:       data_next = resp[39:32];
          4:       data_next = resp[31:24];
          5:       data_next = resp[23:16];
          6:       data_next = resp[15:8];
          7: begin
            data_next  = resp[7:0];
            resp_done  = 1'b1;
            state_next = rx2;
          end
          default: data_next = 8'h00;
        endcase
      end

      rx2: begin
        round_bytes_next = round_bytes + 7'd1;
        data_next        = us_tdata[23:16];
        if (round_bytes == '0) mic_bit_next = us_tuser;  // First receiver feeds the mic slot
        state_next       = sub_end ? after_sub : rx1;
      end

      rx1: begin
        round_bytes_next = round_bytes + 7'd1;
        data_next        = us_tdata[15:8];
        state_next       = sub_end ? after_sub : rx0;
      end

      rx0: begin
        round_bytes_next = round_bytes + 7'd1;
        data_next        = us_tdata[7:0];
        us_tready        = us_tvalid;
        if (sub_end) state_next = after_sub;
        else state_next = us_tlast ? mic1 : rx2;
      end

      mic1: begin
        round_bytes_next = round_bytes + 7'd1;
        data_next        = 8'h00;
        state_next       = sub_end ? after_sub : mic0;
      end

      mic0: begin
        round_bytes_next = '0;
        data_next        = vna ? {7'd0, mic_bit} : 8'h00;
        // Room left for a full round?
        if (sub_end) state_next = after_sub;
        else state_next = (sub_pos > SUB_W'(round_bytes)) ? rx2 : pad;
      end

      pad: begin
        data_next = 8'h00;
        if (sub_end) state_next = after_sub;
      end

      default: state_next = idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= idle;
      byte_no       <= '0;
      udp_tx_length <= '0;
      disc_pending  <= 1'b0;
    end else begin
      state         <= state_next;
      byte_no       <= byte_no_next;
      udp_tx_length <= tx_len_next;
      if (discovery) disc_pending <= 1'b1;
      else if (disc_done) disc_pending <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    data_q      <= data_next;
    round_bytes <= round_bytes_next;
    mic_bit     <= mic_bit_next;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ep6_seq     <= '0;
      ep4_seq     <= '0;
      bs_cnt      <= 7'd1;
      resp_toggle <= 1'b0;
      watchdog_up <= 1'b0;
    end else begin
      if (!run) begin
        ep6_seq <= '0;
        ep4_seq <= '0;
      end else begin
        if (ep6_inc) ep6_seq <= ep6_seq + 32'd1;
        if (ep4_inc) ep4_seq <= ep4_seq + 32'd1;
      end
      if (wide_start) begin
        bs_cnt      <= rx_round_cnt;
        watchdog_up <= ~watchdog_up;
      end else if (ep6_inc && bs_cnt != '0) begin
        bs_cnt <= bs_cnt - 7'd1;
      end
      if (resp_done) resp_toggle <= ~resp_toggle;
    end
  end

  // MAC grant must release the request on the next clock
  a_req_release: assert property (@(posedge clk) disable iff (!rst_n)
    udp_tx_request && udp_tx_enable |=> !udp_tx_request);

  a_state_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(state));

endmodule

// ==== source/upstream_top.sv ====
// Upstream packer top level
`timescale 1ns/100ps

module upstream_top import hpsdr_pkg::*; #(
  parameter logic [7:0] NR            = 8'd1,
  parameter logic [7:0] SERIAL_NO     = 8'd0,
  parameter logic [7:0] HARD_STATUS1  = 8'h40,
  parameter logic [7:0] BOARD_ID      = 8'h06,
  parameter int         US_DEPTH_LOG2 = 9,
  parameter int         BS_DEPTH_LOG2 = 10
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             psel,
  input  logic             penable,
  input  logic             pwrite,
  input  logic [5:0]       paddr,
  input  logic [31:0]      pwdata,
  output logic [31:0]      prdata,
  input  logic             us_wr,
  input  logic [23:0]      us_wdata,
  input  logic             us_wuser,
  input  logic             us_wlast,
  input  logic             bs_wr,
  input  logic [11:0]      bs_wdata,
  input  logic             run,
  input  logic             have_ip,
  input  logic             wide_spectrum,
  input  logic             discovery,
  output logic             udp_tx_request,
  output logic [LEN_W-1:0] udp_tx_length,
  output logic [7:0]       udp_tx_data,
  input  logic             udp_tx_enable,
  output logic             watchdog_up
);

  logic [25:0]            us_rdata;  // {last, user, sample}
  logic [US_DEPTH_LOG2:0] us_level;
  logic [LEN_W-1:0]       us_tlength;
  logic                   us_tvalid, us_tready;
  logic [11:0]            bs_tdata;
  logic                   bs_tvalid, bs_tready;
  logic [6:0]             rx_round_cnt;
  logic                   vna, resp_toggle;
  logic [47:0]            mac;
  logic [31:0]            static_ip;
  logic [15:0]            alt_mac;
  logic [7:0]             eeprom_config;
  logic [39:0]            resp;

  assign us_tlength = LEN_W'(us_level);

  sample_fifo #(.WIDTH(26), .DEPTH_LOG2(US_DEPTH_LOG2)) i_us_fifo (
    .clk, .rst_n, .wr(us_wr), .wdata({us_wlast, us_wuser, us_wdata}),
    .rd(us_tready), .rdata(us_rdata), .valid(us_tvalid), .level(us_level)
  );

  sample_fifo #(.WIDTH(12), .DEPTH_LOG2(BS_DEPTH_LOG2)) i_bs_fifo (
    .clk, .rst_n, .wr(bs_wr), .wdata(bs_wdata),
    .rd(bs_tready), .rdata(bs_tdata), .valid(bs_tvalid), .level()
  );

  cmd_regs i_regs (
    .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
    .rx_round_cnt, .vna, .mac, .static_ip, .alt_mac, .eeprom_config,
    .resp, .resp_toggle
  );

  upstream_packer #(
    .NR(NR), .SERIAL_NO(SERIAL_NO), .HARD_STATUS1(HARD_STATUS1), .BOARD_ID(BOARD_ID)
  ) i_packer (
    .clk, .rst_n, .run, .have_ip, .wide_spectrum, .discovery,
    .mac, .static_ip, .alt_mac, .eeprom_config, .vna, .rx_round_cnt,
    .resp, .resp_toggle,
    .us_tvalid, .us_tready, .us_tdata(us_rdata[23:0]), .us_tuser(us_rdata[24]),
    .us_tlast(us_rdata[25]), .us_tlength,
    .bs_tvalid, .bs_tready, .bs_tdata,
    .udp_tx_request, .udp_tx_length, .udp_tx_data, .udp_tx_enable,
    .watchdog_up
  );

endmodule

// ==== sim/frame_model.svh ====
// Expected frame builders
`ifndef FRAME_MODEL_SVH
`define FRAME_MODEL_SVH

// Big endian word into the expected bytes
function automatic void push_word(input logic [31:0] w);
  exp_q.push_back(w[31:24]);
  exp_q.push_back(w[23:16]);
  exp_q.push_back(w[15:8]);
  exp_q.push_back(w[7:0]);
endfunction

function automatic void build_disc();
  exp_q.delete();
  exp_q.push_back(MAGIC0);
  exp_q.push_back(MAGIC1);
  exp_q.push_back(run ? 8'h03 : 8'h02);
  exp_q.push_back(reg_val[2][15:8]);  // MAC, high half first
  exp_q.push_back(reg_val[2][7:0]);
  push_word(reg_val[3]);
  exp_q.push_back(SERIAL_NO);
  exp_q.push_back({reg_val[6][7:5], 5'd0});
  exp_q.push_back(8'h00);
  push_word(reg_val[4]);
  exp_q.push_back(reg_val[5][15:8]);
  exp_q.push_back(reg_val[5][7:0]);
  exp_q.push_back(NR);
  exp_q.push_back(HARD_STATUS1);
  while (exp_q.size() < DISC_LEN) exp_q.push_back(BOARD_ID);
endfunction

function automatic void build_ep6(input bit vna);
  logic [25:0] w;
  int          left;
  int          len;
  int          k;
  bit          ub;
  exp_q.delete();
  push_word({MAGIC0, MAGIC1, 8'h01, EP6_ID});
  push_word(ep6_seq_m);
  for (int sf = 0; sf < 2; sf++) begin
    repeat (3) exp_q.push_back(SYNC_BYTE);
    exp_q.push_back(reg_val[7][7:0]);
    push_word(reg_val[8]);
    left = SUBFRAME_LEN - 8;
    len  = 0;
    // A new round only when the last one would still fit
    while (left > 0 && left >= len && us_q.size() > 0) begin
      k  = 0;
      ub = 1'b0;
      do begin
        w = us_q.pop_front();
        if (k == 0) ub = w[24];
        exp_q.push_back(w[23:16]);
        exp_q.push_back(w[15:8]);
        exp_q.push_back(w[7:0]);
        k++;
      end while (!w[25] && us_q.size() > 0);
      exp_q.push_back(8'h00);
      exp_q.push_back(vna ? {7'd0, ub} : 8'h00);
      len  = 3 * k + 2;
      left = left - len;
    end
    repeat (left) exp_q.push_back(8'h00);
  end
endfunction

function automatic void build_ep4();
  logic [11:0] s;
  exp_q.delete();
  push_word({MAGIC0, MAGIC1, 8'h01, EP4_ID});
  push_word(ep4_seq_m);
  repeat (512) begin
    s = bs_q.pop_front();
    exp_q.push_back({s[3:0], 4'h0});
    exp_q.push_back(s[11:4]);
  end
endfunction

`endif

// ==== sim/tb_upstream.sv ====
// Upstream packer testbench
`timescale 1ns/100ps

module tb_upstream import hpsdr_pkg::*; ();

  localparam logic [7:0] NR           = 8'd2;
  localparam logic [7:0] SERIAL_NO    = 8'h12;
  localparam logic [7:0] HARD_STATUS1 = 8'h40;
  localparam logic [7:0] BOARD_ID     = 8'h06;
  localparam int         ROWS         = 8;

  logic             clk = 1'b0;
  logic             rst_n = 1'b0;
  logic             psel = 1'b0, penable = 1'b0, pwrite = 1'b0;
  logic [5:0]       paddr = '0;
  logic [31:0]      pwdata = '0, prdata;
  logic             us_wr = 1'b0, us_wuser = 1'b0, us_wlast = 1'b0;
  logic [23:0]      us_wdata = '0;
  logic             bs_wr = 1'b0;
  logic [11:0]      bs_wdata = '0;
  logic             run = 1'b0, have_ip = 1'b0, wide_spectrum = 1'b0, discovery = 1'b0;
  logic             udp_tx_request, udp_tx_enable = 1'b0, watchdog_up;
  logic [LEN_W-1:0] udp_tx_length;
  logic [7:0]       udp_tx_data;

  integer      seed;
  int          err_cnt, fail_tests;
  logic [25:0] us_q[$];  // Words in the sample FIFO, {last, user, sample}
  logic [11:0] bs_q[$];
  logic [7:0]  got_q[$], exp_q[$];
  logic [31:0] reg_val[9];
  reg_addr_e   reg_adr[9];
  logic [31:0] ep6_seq_m, ep4_seq_m;
  logic [6:0]  bs_cnt_m;
  logic        wd_m;

  string t_name[ROWS];
  int    t_nrx[ROWS], t_speed[ROWS], t_frames[ROWS];
  bit    t_vna[ROWS], t_run[ROWS], t_wide[ROWS], t_disc[ROWS], t_rst[ROWS];

  always #10 clk = ~clk;

  upstream_top #(
    .NR(NR), .SERIAL_NO(SERIAL_NO), .HARD_STATUS1(HARD_STATUS1), .BOARD_ID(BOARD_ID)
  ) i_dut (
    .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
    .us_wr, .us_wdata, .us_wuser, .us_wlast, .bs_wr, .bs_wdata,
    .run, .have_ip, .wide_spectrum, .discovery,
    .udp_tx_request, .udp_tx_length, .udp_tx_data, .udp_tx_enable, .watchdog_up
  );

  `include "frame_model.svh"

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic set_row(input int i, input string name, input int nrx, input int spd,
                         input bit vna, input bit rn, input bit wide, input bit disc,
                         input bit rst, input int frames);
    t_name[i]   = name;
    t_nrx[i]    = nrx;
    t_speed[i]  = spd;
    t_vna[i]    = vna;
    t_run[i]    = rn;
    t_wide[i]   = wide;
    t_disc[i]   = disc;
    t_rst[i]    = rst;
    t_frames[i] = frames;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    us_q.delete();
    bs_q.delete();
    ep6_seq_m = '0;
    ep4_seq_m = '0;
    bs_cnt_m  = 7'd1;
    wd_m      = 1'b0;
    @(negedge clk);
    check_value("udp_tx_request", 32'(udp_tx_request), 32'h0);
    check_value("watchdog_up", 32'(watchdog_up), 32'h0);
  endtask

  task automatic apb_write(input logic [5:0] a, input logic [31:0] d);
    @(posedge clk);
    psel    <= 1'b1;
    pwrite  <= 1'b1;
    paddr   <= a;
    pwdata  <= d;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input logic [5:0] a, output logic [31:0] d);
    @(posedge clk);
    psel    <= 1'b1;
    pwrite  <= 1'b0;
    paddr   <= a;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    d = prdata;  // Access phase
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // Whole rounds, each receiver word with its own user bit
  task automatic push_us(input int target, input int nrx);
    logic [31:0] tmp;
    bit          ub;
    while (us_q.size() < target) begin
      for (int r = 0; r < nrx; r++) begin
        tmp = $random(seed);
        ub  = tmp[31];
        @(posedge clk);
        us_wr    <= 1'b1;
        us_wdata <= tmp[23:0];
        us_wuser <= ub;
        us_wlast <= (r == nrx - 1);
        us_q.push_back({r == nrx - 1, ub, tmp[23:0]});
      end
    end
    @(posedge clk);
    us_wr <= 1'b0;
  endtask

  task automatic push_bs(input int target);
    logic [31:0] tmp;
    while (bs_q.size() < target) begin
      tmp = $random(seed);
      @(posedge clk);
      bs_wr    <= 1'b1;
      bs_wdata <= tmp[11:0];
      bs_q.push_back(tmp[11:0]);
    end
    @(posedge clk);
    bs_wr <= 1'b0;
  endtask

  // MAC model, grants after a random delay and collects the bytes
  task automatic capture_frame(input int len, output bit ok);
    int t;
    int dly;
    got_q.delete();
    ok = 1'b0;
    t  = 0;
    @(negedge clk);
    while (!udp_tx_request && t < 5000) begin
      @(negedge clk);
      t++;
    end
    if (!udp_tx_request) begin
      $display("No frame request from the DUT within 5000 cycles");
      err_cnt++;
      return;
    end
    check_value("udp_tx_length", 32'(udp_tx_length), 32'(len));
    dly = $unsigned($random(seed)) % 8;
    repeat (dly) @(posedge clk);
    @(posedge clk);
    udp_tx_enable <= 1'b1;
    @(posedge clk);
    udp_tx_enable <= 1'b0;
    repeat (len) begin
      @(negedge clk);
      got_q.push_back(udp_tx_data);
    end
    ok = 1'b1;
  endtask

  task automatic compare_frame();
    int e0;
    e0 = err_cnt;
    for (int i = 0; i < exp_q.size() && err_cnt - e0 < 5; i++) begin
      check_value($sformatf("udp_tx_data[%0d]", i), 32'(got_q[i]), 32'(exp_q[i]));
    end
  endtask

  task automatic run_row(input int i);
    int          e0;
    int          n_ep6;
    int          hits;
    logic [31:0] rd;
    logic [31:0] sent0;
    logic [31:0] tmp;
    bit          ok;
    bit          ep6;
    e0    = err_cnt;
    n_ep6 = 0;
    if (t_rst[i]) apply_reset();
    @(posedge clk);
    have_ip       <= 1'b0;
    wide_spectrum <= 1'b0;
    run           <= t_run[i];
    if (!t_run[i]) begin
      ep6_seq_m = '0;
      ep4_seq_m = '0;
    end
    reg_val[0] = {6'd0, 2'(t_speed[i]), 16'd0, 5'(t_nrx[i] - 1), 3'd0};
    reg_val[1] = {8'd0, t_vna[i], 23'd0};
    for (int k = 2; k < 9; k++) begin
      tmp        = $random(seed);
      reg_val[k] = tmp;
    end
    reg_val[2] = reg_val[2] & 32'h0000_ffff;
    reg_val[5] = reg_val[5] & 32'h0000_ffff;
    reg_val[6] = reg_val[6] & 32'h0000_00ff;
    reg_val[7] = reg_val[7] & 32'h0000_00ff;
    for (int k = 0; k < 9; k++) apb_write(reg_adr[k], reg_val[k]);
    for (int k = 0; k < 9; k++) begin
      apb_read(reg_adr[k], rd);
      check_value($sformatf("prdata[%s]", reg_adr[k].name()), rd, reg_val[k]);
    end
    apb_read(addr_resp_sent, sent0);

    if (t_disc[i]) begin
      @(posedge clk);
      discovery <= 1'b1;
      @(posedge clk);
      discovery <= 1'b0;
      capture_frame(DISC_LEN, ok);
      build_disc();
      if (ok) compare_frame();
    end

    // Run low, so a full FIFO must not start a frame
    if (!t_run[i] && !t_disc[i]) begin
      push_us(500, t_nrx[i]);
      @(posedge clk);
      have_ip <= 1'b1;
      hits = 0;
      repeat (100) begin
        @(negedge clk);
        if (udp_tx_request) hits++;
      end
      check_value("udp_tx_request cycles", 32'(hits), 32'h0);
    end

    for (int f = 0; f < t_frames[i]; f++) begin
      if (!(t_wide[i] && bs_cnt_m == '0 && bs_q.size() > 0 &&
            us_q.size() < EP6_THRESHOLD)) begin
        @(posedge clk);
        have_ip       <= 1'b0;
        wide_spectrum <= 1'b0;
        push_us(400, t_nrx[i]);
        if (t_wide[i]) push_bs(600);
        @(posedge clk);
        have_ip       <= 1'b1;
        wide_spectrum <= t_wide[i];
      end
      ep6 = us_q.size() >= EP6_THRESHOLD;
      capture_frame(FRAME_LEN, ok);
      if (!ok) break;
      if (ep6) begin
        build_ep6(t_vna[i]);
        ep6_seq_m++;
        n_ep6++;
        if (bs_cnt_m != '0) bs_cnt_m--;
      end else begin
        build_ep4();
        ep4_seq_m++;
        bs_cnt_m = 7'(t_nrx[i] << t_speed[i]);
        wd_m     = ~wd_m;
      end
      compare_frame();
      check_value("watchdog_up", 32'(watchdog_up), 32'(wd_m));
    end

    apb_read(addr_resp_sent, rd);
    check_value("resp_sent", rd, sent0 + 32'(2 * n_ep6));  // Two subframes each
    @(posedge clk);
    have_ip       <= 1'b0;
    wide_spectrum <= 1'b0;
    if (err_cnt != e0) fail_tests++;
    $display("%-16s %s", t_name[i], (err_cnt == e0) ? "ok" : "FAILED");
  endtask

  initial begin
    seed       = 32'h0305_90b3;
    err_cnt    = 0;
    fail_tests = 0;
    reg_adr    = '{addr_rx_cfg, addr_vna_cfg, addr_mac_hi, addr_mac_lo, addr_static_ip,
                   addr_alt_mac, addr_eeprom, addr_resp_hi, addr_resp_lo};
    //          name            nrx spd vna run wide disc rst frames
    set_row(0, "disc_idle",      1,  0,  0,  0,  0,   1,   1,  0);
    set_row(1, "disc_run",       1,  0,  0,  1,  0,   1,   0,  0);
    set_row(2, "ep6_one_rx",     1,  0,  0,  1,  0,   0,   1,  3);
    set_row(3, "run_low",        1,  0,  0,  0,  0,   0,   0,  0);
    set_row(4, "ep6_restart",    1,  0,  0,  1,  0,   0,   0,  2);
    set_row(5, "ep6_two_rx_vna", 2,  1,  1,  1,  0,   0,   1,  2);
    set_row(6, "ep4_one_rx",     1,  0,  0,  1,  1,   0,   1,  4);
    set_row(7, "ep4_two_rx",     2,  1,  0,  1,  1,   0,   1,  7);
    for (int i = 0; i < ROWS; i++) run_row(i);
    $display("%0d tests, %0d failed, %0d check errors", ROWS, fail_tests, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+sim
source/hpsdr_pkg.sv
source/sample_fifo.sv
source/cmd_regs.sv
source/upstream_packer.sv
source/upstream_top.sv
sim/tb_upstream.sv

// ==== Makefile ====
# Verilator build for the upstream packer testbench

VERILATOR  ?= verilator
TOP        ?= tb_upstream
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
PASS_TEXT  ?= All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
